// File: ecc_code_pkg.sv
package ecc_code_pkg;

    localparam int data_width = 20;
    localparam int parity_width = 6;
    localparam int code_width = data_width + parity_width;

    typedef logic [data_width-1:0] ecc_data_t;
    typedef logic [parity_width-1:0] ecc_parity_t;
    typedef logic [parity_width-1:0] ecc_syndrome_t;

    // Bits 0 to 19 hold the data and bits 20 to 25 the check bits.
    typedef struct packed {
        ecc_parity_t parity;
        ecc_data_t   data;
    } ecc_codeword_t;

    typedef enum logic [1:0] {
        ECC_CLEAN         = 2'b00,
        ECC_CORRECTED     = 2'b01,
        ECC_UNCORRECTABLE = 2'b10
    } ecc_status_e;

    // Data bits covered by each check bit.
    localparam ecc_data_t p0_cover = 20'hAAD5B;
    localparam ecc_data_t p1_cover = 20'h3366D;
    localparam ecc_data_t p2_cover = 20'h3C78E;
    localparam ecc_data_t p3_cover = 20'hC07F0;
    localparam ecc_data_t p4_cover = 20'hFF800;
    localparam ecc_data_t p5_cover = 20'h65CB7;

    function automatic ecc_parity_t ecc_encode(input ecc_data_t d);
        ecc_parity_t p;
        p[0] = ^(d & p0_cover);
        p[1] = ^(d & p1_cover);
        p[2] = ^(d & p2_cover);
        p[3] = ^(d & p3_cover);
        p[4] = ^(d & p4_cover);
        p[5] = ^(d & p5_cover); // Every data column has odd weight.
        return p;
    endfunction

endpackage

// File: ecc_bus_pkg.sv
package ecc_bus_pkg;

    typedef enum logic {
        ECC_OP_CHECKED = 1'b0,
        ECC_OP_BYPASS  = 1'b1
    } ecc_op_e;

    typedef struct packed {
        ecc_op_e                             op;
        ecc_code_pkg::ecc_data_t             data;
        logic [ecc_code_pkg::code_width-1:0] flip_mask; // Bit i flips codeword bit i.
    } ecc_wr_req_t;

    typedef struct packed {
        ecc_op_e                     op;
        ecc_code_pkg::ecc_codeword_t code;
    } ecc_word_t;

    typedef struct packed {
        ecc_code_pkg::ecc_data_t     data;
        ecc_code_pkg::ecc_status_e   status;
        ecc_code_pkg::ecc_syndrome_t syndrome;
    } ecc_rsp_t;

endpackage

// File: ecc20_encoder.sv
`timescale 1ns/10ps

module ecc20_encoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  ecc_bus_pkg::ecc_wr_req_t req,
    output logic                     enc_valid,
    input  logic                     enc_ready,
    output ecc_bus_pkg::ecc_word_t   enc_word
);

    ecc_code_pkg::ecc_codeword_t clean_code;
    ecc_code_pkg::ecc_codeword_t stored_code;
    logic                        accept;

    assign clean_code.data = req.data;
    assign clean_code.parity = ecc_code_pkg::ecc_encode(req.data);

    // Injected faults land after encoding, as if the storage cells flipped.
    assign stored_code = ecc_code_pkg::ecc_codeword_t'(clean_code ^ req.flip_mask);

    assign req_ready = !enc_valid || enc_ready; // Register empty or draining this cycle.
    assign accept = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enc_valid <= 1'b0;
        end else if (req_ready) begin
            enc_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            enc_word.op <= req.op;
            enc_word.code <= stored_code;
        end
    end

    a_enc_word_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        enc_valid && !enc_ready |=> enc_valid && $stable(enc_word)
    );

endmodule

// File: ecc20_word_fifo.sv
`timescale 1ns/10ps

module ecc20_word_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enc_valid,
    output logic                   enc_ready,
    input  ecc_bus_pkg::ecc_word_t enc_word,
    output logic                   buf_valid,
    input  logic                   buf_ready,
    output ecc_bus_pkg::ecc_word_t buf_word
);

    localparam int addr_width = $clog2(fifo_depth);

    ecc_bus_pkg::ecc_word_t mem [fifo_depth];

    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] rd_ptr;
    logic [addr_width:0] count;
    logic                full;
    logic                empty;
    logic                push;
    logic                pop;

    // The extra pointer bit tells a full buffer from an empty one.
    assign empty = wr_ptr == rd_ptr;
    assign full = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                  (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);
    assign count = wr_ptr - rd_ptr;

    assign enc_ready = !full;
    assign buf_valid = !empty;
    assign push = enc_valid && enc_ready;
    assign pop = buf_valid && buf_ready;

    assign buf_word = mem[rd_ptr[addr_width-1:0]]; // Head is read without a register.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[addr_width-1:0]] <= enc_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    a_count_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(count) <= fifo_depth
    );

    a_ptr_order : assert property (
        @(posedge clk) disable iff (!rst_n)
        ##1 int'(count) == int'($past(count)) + int'($past(push)) - int'($past(pop))
    );

endmodule

// File: ecc20_decoder.sv
`timescale 1ns/10ps

module ecc20_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   buf_valid,
    output logic                   buf_ready,
    input  ecc_bus_pkg::ecc_word_t buf_word,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output ecc_bus_pkg::ecc_rsp_t  rsp
);

    ecc_code_pkg::ecc_syndrome_t syndrome;
    ecc_code_pkg::ecc_data_t     fix_mask;
    ecc_code_pkg::ecc_status_e   status;
    ecc_bus_pkg::ecc_rsp_t       rsp_next;
    logic [4:0]                  bit_idx;
    logic                        bit_hit;
    logic                        take;

    assign syndrome = buf_word.code.parity ^ ecc_code_pkg::ecc_encode(buf_word.code.data);

    // Each data bit has its own syndrome column.
    always_comb begin
        bit_hit = 1'b1;
        bit_idx = 5'd0;
        case (syndrome)
            6'b100011: bit_idx = 5'd0;
            6'b100101: bit_idx = 5'd1;
            6'b100110: bit_idx = 5'd2;
            6'b000111: bit_idx = 5'd3;
            6'b101001: bit_idx = 5'd4;
            6'b101010: bit_idx = 5'd5;
            6'b001011: bit_idx = 5'd6;
            6'b101100: bit_idx = 5'd7;
            6'b001101: bit_idx = 5'd8;
            6'b001110: bit_idx = 5'd9;
            6'b101111: bit_idx = 5'd10;
            6'b110001: bit_idx = 5'd11;
            6'b110010: bit_idx = 5'd12;
            6'b010011: bit_idx = 5'd13;
            6'b110100: bit_idx = 5'd14;
            6'b010101: bit_idx = 5'd15;
            6'b010110: bit_idx = 5'd16;
            6'b110111: bit_idx = 5'd17;
            6'b111000: bit_idx = 5'd18;
            6'b011001: bit_idx = 5'd19;
            default:   bit_hit = 1'b0;
        endcase
    end

    assign fix_mask = bit_hit ? ecc_code_pkg::ecc_data_t'(1) << bit_idx : '0;

    always_comb begin
        if (syndrome == '0) begin
            status = ecc_code_pkg::ECC_CLEAN;
        end else if (bit_hit || $onehot(syndrome)) begin
            status = ecc_code_pkg::ECC_CORRECTED; // A lone check bit leaves the data as is.
        end else begin
            status = ecc_code_pkg::ECC_UNCORRECTABLE;
        end
    end

    always_comb begin
        rsp_next.syndrome = syndrome;
        if (buf_word.op == ecc_bus_pkg::ECC_OP_BYPASS) begin
            rsp_next.data = buf_word.code.data;
            rsp_next.status = ecc_code_pkg::ECC_CLEAN;
        end else begin
            rsp_next.data = buf_word.code.data ^ fix_mask;
            rsp_next.status = status;
        end
    end

    assign buf_ready = !rsp_valid || rsp_ready;
    assign take = buf_valid && buf_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (buf_ready) begin
            rsp_valid <= buf_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rsp <= rsp_next;
        end
    end

    a_rsp_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
    );

endmodule

// File: ecc20_top.sv
`timescale 1ns/10ps

module ecc20_top #(
    parameter int fifo_depth = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  ecc_bus_pkg::ecc_wr_req_t req,
    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output ecc_bus_pkg::ecc_rsp_t    rsp
);

    logic                   enc_valid;
    logic                   enc_ready;
    ecc_bus_pkg::ecc_word_t enc_word;
    logic                   buf_valid;
    logic                   buf_ready;
    ecc_bus_pkg::ecc_word_t buf_word;

    ecc20_encoder i_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .enc_valid (enc_valid),
        .enc_ready (enc_ready),
        .enc_word  (enc_word)
    );

    ecc20_word_fifo #(
        .fifo_depth (fifo_depth)
    ) i_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .enc_valid (enc_valid),
        .enc_ready (enc_ready),
        .enc_word  (enc_word),
        .buf_valid (buf_valid),
        .buf_ready (buf_ready),
        .buf_word  (buf_word)
    );

    ecc20_decoder i_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .buf_valid (buf_valid),
        .buf_ready (buf_ready),
        .buf_word  (buf_word),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: tb_ecc20.sv
`timescale 1ns/10ps

module tb_ecc20;

    localparam int num_fixed = 11;
    localparam int num_data_flip = ecc_code_pkg::data_width;
    localparam int num_parity_flip = ecc_code_pkg::parity_width;
    localparam int num_entries = num_fixed + num_data_flip + num_parity_flip;
    localparam int timeout_cycles = num_entries * 20 + 100;
    localparam logic [31:0] seed = 32'd85387;

    typedef logic [ecc_code_pkg::code_width-1:0] mask_t;

    typedef struct packed {
        ecc_bus_pkg::ecc_op_e        op;
        ecc_code_pkg::ecc_data_t     data;
        mask_t                       flip_mask;
        ecc_code_pkg::ecc_data_t     exp_data;
        ecc_code_pkg::ecc_status_e   exp_status;
        ecc_code_pkg::ecc_syndrome_t exp_syndrome;
        logic                        data_checked;
        logic                        syndrome_checked;
    } entry_t;

    logic                     clk;
    logic                     rst_n;
    logic                     req_valid;
    logic                     req_ready;
    ecc_bus_pkg::ecc_wr_req_t req;
    logic                     rsp_valid;
    logic                     rsp_ready;
    ecc_bus_pkg::ecc_rsp_t    rsp;

    entry_t      table_a [num_entries];
    logic [31:0] rng_state;
    int          rx_count = 0;
    int          cycle_count = 0;
    int          data_errors = 0;
    int          status_errors = 0;
    int          syndrome_errors = 0;
    int          other_errors = 0;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ecc20_top #(
        .fifo_depth (4)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic entry_t make_entry(input ecc_bus_pkg::ecc_op_e op,
                                          input ecc_code_pkg::ecc_data_t data,
                                          input mask_t mask);
        entry_t e;
        e.op = op;
        e.data = data;
        e.flip_mask = mask;
        e.exp_data = data;
        e.data_checked = 1'b1;
        // With clean data bits the syndrome is just the flipped check bits.
        e.exp_syndrome = mask[ecc_code_pkg::code_width-1:ecc_code_pkg::data_width];
        e.syndrome_checked = mask[ecc_code_pkg::data_width-1:0] == '0;
        if (op == ecc_bus_pkg::ECC_OP_BYPASS) begin
            e.exp_data = data ^ mask[ecc_code_pkg::data_width-1:0];
            e.exp_status = ecc_code_pkg::ECC_CLEAN;
        end else if ($countones(mask) == 0) begin
            e.exp_status = ecc_code_pkg::ECC_CLEAN;
        end else if ($countones(mask) == 1) begin
            e.exp_status = ecc_code_pkg::ECC_CORRECTED;
        end else begin
            e.exp_status = ecc_code_pkg::ECC_UNCORRECTABLE;
            // Data can only be trusted when both flips hit check bits.
            e.data_checked = mask[ecc_code_pkg::data_width-1:0] == '0;
        end
        return e;
    endfunction

    task automatic build_table();
        table_a[0] = make_entry(ecc_bus_pkg::ECC_OP_CHECKED, 20'h00000, '0);
        table_a[1] = make_entry(ecc_bus_pkg::ECC_OP_CHECKED, 20'hFFFFF, '0);
        table_a[2] = make_entry(ecc_bus_pkg::ECC_OP_CHECKED, 20'h5A5A5, '0);
        table_a[3] = make_entry(ecc_bus_pkg::ECC_OP_CHECKED, 20'h12345, '0);
        table_a[4] = make_entry(ecc_bus_pkg::ECC_OP_CHECKED, 20'hABCDE, mask_t'(26'h2100000));
        table_a[5] = make_entry(ecc_bus_pkg::ECC_OP_CHECKED, 20'h0F0F0, mask_t'(26'h0A00000));
        table_a[6] = make_entry(ecc_bus_pkg::ECC_OP_CHECKED, 20'h13579, mask_t'(26'h0020008));
        table_a[7] = make_entry(ecc_bus_pkg::ECC_OP_CHECKED, 20'h2468A, mask_t'(26'h0400001));
        table_a[8] = make_entry(ecc_bus_pkg::ECC_OP_BYPASS, 20'h55555, mask_t'(26'h0000080));
        table_a[9] = make_entry(ecc_bus_pkg::ECC_OP_BYPASS, 20'hC3C3C, mask_t'(26'h1000010));
        table_a[10] = make_entry(ecc_bus_pkg::ECC_OP_BYPASS, 20'h9E37A, '0);
        for (int i = 0; i < num_data_flip; i++) begin
            rng_state = xorshift32(rng_state);
            table_a[num_fixed + i] = make_entry(ecc_bus_pkg::ECC_OP_CHECKED,
                                                rng_state[19:0], mask_t'(1) << i);
        end
        for (int i = 0; i < num_parity_flip; i++) begin
            rng_state = xorshift32(rng_state);
            table_a[num_fixed + num_data_flip + i] = make_entry(
                ecc_bus_pkg::ECC_OP_CHECKED, rng_state[19:0],
                mask_t'(1) << (ecc_code_pkg::data_width + i));
        end
    endtask

    task automatic check_data(input int idx, input ecc_code_pkg::ecc_data_t exp,
                              input ecc_code_pkg::ecc_data_t act);
        if (act !== exp) begin
            $display("ERROR entry %0d rsp.data expected 0x%05h got 0x%05h", idx, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_status(input int idx, input ecc_code_pkg::ecc_status_e exp,
                                input ecc_code_pkg::ecc_status_e act);
        if (act !== exp) begin
            $display("ERROR entry %0d rsp.status expected 0x%0h got 0x%0h", idx, exp, act);
            status_errors++;
        end
    endtask

    task automatic check_syndrome(input int idx, input ecc_code_pkg::ecc_syndrome_t exp,
                                  input ecc_code_pkg::ecc_syndrome_t act);
        if (act !== exp) begin
            $display("ERROR entry %0d rsp.syndrome expected 0x%02h got 0x%02h",
                     idx, exp, act);
            syndrome_errors++;
        end
    endtask

    task automatic send_entry(input entry_t e);
        req_valid = 1'b1;
        req.op = e.op;
        req.data = e.data;
        req.flip_mask = e.flip_mask;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // Driver and closing report.
    initial begin
        req_valid = 1'b0;
        req = '0;
        rng_state = seed;
        build_table();
        @(posedge rst_n);
        @(posedge clk);
        #1;
        for (int i = 0; i < num_entries; i++) begin
            send_entry(table_a[i]);
        end
        req_valid = 1'b0;
        wait (rx_count >= num_entries);
        repeat (10) @(posedge clk); // Leaves room for a stray extra response to show up.
        $display("Error counts: data %0d, status %0d, syndrome %0d, other %0d",
                 data_errors, status_errors, syndrome_errors, other_errors);
        if (data_errors + status_errors + syndrome_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Receiver with random back-pressure.
    initial begin
        rsp_ready = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1;
            rng_state = xorshift32(rng_state);
            rsp_ready = (rng_state % 3) != 0;
            @(negedge clk);
            if (rsp_valid && rsp_ready) begin
                if (rx_count < num_entries) begin
                    if (table_a[rx_count].data_checked) begin
                        check_data(rx_count, table_a[rx_count].exp_data, rsp.data);
                    end
                    check_status(rx_count, table_a[rx_count].exp_status, rsp.status);
                    if (table_a[rx_count].syndrome_checked) begin
                        check_syndrome(rx_count, table_a[rx_count].exp_syndrome,
                                       rsp.syndrome);
                    end
                end else begin
                    $display("A response came back after all %0d entries had returned",
                             num_entries);
                    other_errors++;
                end
                rx_count++;
            end
        end
    end

    initial begin
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("The run timed out after %0d cycles with only %0d of %0d responses back",
                 cycle_count, rx_count, num_entries);
        $display("Error counts: data %0d, status %0d, syndrome %0d, other %0d",
                 data_errors, status_errors, syndrome_errors, other_errors + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: ecc20_store.f
ecc_code_pkg.sv
ecc_bus_pkg.sv
ecc20_encoder.sv
ecc20_word_fifo.sv
ecc20_decoder.sv
ecc20_top.sv
tb_clock_gen.sv
tb_ecc20.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ecc20 -f ecc20_store.f
./obj_dir/Vtb_ecc20 > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0
